// ==== include/cpu_regs_macros.svh ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared constants for the general-register block.
// Bank codes seen in the upper nibble of a raw
// register code, and the dump port address map.
// Include after the package import in any file that
// decodes codes or dump addresses.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef CPU_REGS_MACROS_SVH
`define CPU_REGS_MACROS_SVH

// bank-relative nibbles, resolved against rfp
`define REG_CUR_BANK  4'he
`define REG_PREV_BANK 4'hd

// source nibble that reads as constant zero
`define REG_ZERO_BANK 4'h4

// dump map: general bytes below the pointer base
`define DUMP_PTR_BASE 8'h40
`define DUMP_SR_BASE  8'h50

`endif

// ==== verilog/cpu_regs_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Types shared by the register mapper, the storage
// array and the interface joining them.
// Import with a wildcard in the module header.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package cpu_regs_pkg;

    // general register view, bank and index form the byte address
    typedef struct packed {
        logic [1:0] pad;
        logic [1:0] bank;
        logic [3:0] idx;
    } acc_code_t;

    // pointer register view, bit 7 set
    typedef struct packed {
        logic       is_ptr;
        logic [2:0] pad;
        logic [3:0] idx;
    } ptr_code_t;

    typedef union packed {
        acc_code_t acc;
        ptr_code_t ptr;
    } reg_code_t;

    // one-hot write width
    typedef struct packed {
        logic long_w;
        logic word_w;
        logic byte_w;
    } wr_width_t;

    // 1 -> two, 2 -> four, others -> one
    typedef logic [1:0] step_t;

    function automatic logic [31:0] step_bytes(input step_t s);
        case (s)
            2'd1:    return 32'd2;
            2'd2:    return 32'd4;
            default: return 32'd1;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== verilog/reg_port_if.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Physical register codes and the current bank
// pointer, passed from the code mapper to the
// storage array. Combinational, valid every cycle.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

interface reg_port_if import cpu_regs_pkg::*; ();

    reg_code_t  src_code;
    reg_code_t  aux_code;
    reg_code_t  dst_code;
    logic [1:0] rfp;

    modport map (
        output src_code,
        output aux_code,
        output dst_code,
        output rfp
    );

    modport array (
        input src_code,
        input aux_code,
        input dst_code,
        input rfp
    );

endinterface

`default_nettype wire

// ==== verilog/reg_code_map.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register file pointer and code translation.
// Holds rfp and turns bank-relative codes on the
// source, aux and destination paths into physical
// codes for the storage array.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

`include "cpu_regs_macros.svh"

module reg_code_map import cpu_regs_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,
    input  logic       inc_rfp,
    input  logic       dec_rfp,
    input  logic       rfp_we,
    input  logic [1:0] imm,
    input  logic       idx_en,
    input  reg_code_t  src,
    input  reg_code_t  dst,
    input  reg_code_t  idx_rdreg_sel,
    input  reg_code_t  idx_rdreg_aux,
    reg_port_if.map    port
);

    logic [1:0] rfp_q;
    reg_code_t  src_raw;
    reg_code_t  dst_raw;
    reg_code_t  aux_map;

    // replace current/previous bank nibble by a physical bank
    function automatic reg_code_t map_code(input logic [1:0] bank, input reg_code_t raw);
        reg_code_t  mapped;
        logic [3:0] hi;
        hi     = {raw.acc.pad, raw.acc.bank};
        mapped = raw;
        if (hi == `REG_CUR_BANK) begin
            mapped.acc.pad  = 2'b00;
            mapped.acc.bank = bank;
        end else if (hi == `REG_PREV_BANK) begin
            mapped.acc.pad  = 2'b00;
            mapped.acc.bank = bank - 2'd1;
        end
        return mapped;
    endfunction

    // load beats decrement beats increment
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rfp_q <= 2'd0;
        end else if (cen) begin
            if (rfp_we) begin
                rfp_q <= imm;
            end else if (dec_rfp) begin
                rfp_q <= rfp_q - 2'd1;
            end else if (inc_rfp) begin
                rfp_q <= rfp_q + 2'd1;
            end
        end
    end

    // index mode takes both codes from the addresser
    always_comb begin
        src_raw = idx_en ? idx_rdreg_sel : src;
        dst_raw = idx_en ? idx_rdreg_aux : dst;
        aux_map = map_code(rfp_q, idx_rdreg_sel);
        // second index register of a pair
        aux_map.ptr.idx[2] = 1'b0;
    end

    assign port.src_code = map_code(rfp_q, src_raw);
    assign port.dst_code = map_code(rfp_q, dst_raw);
    assign port.aux_code = aux_map;
    assign port.rfp      = rfp_q;

endmodule

`default_nettype wire

// ==== verilog/reg_array.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// General and pointer register storage.
// Three combinational read ports, width-masked
// writes, stepping, block counters, stack pointer,
// the BC flag and a registered dump port.
// Takes physical codes from reg_port_if.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

`include "cpu_regs_macros.svh"

module reg_array import cpu_regs_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    reg_port_if.array   port,
    input  logic [15:0] sr,
    input  step_t       reg_step,
    input  logic        reg_inc,
    input  logic        reg_dec,
    input  logic        dec_xde,
    input  logic        dec_xix,
    input  logic        dec_bc,
    input  logic [2:0]  inc_xsp,
    input  logic [2:0]  dec_xsp,
    input  logic [31:0] alu_dout,
    input  logic [31:0] ram_dout,
    input  logic        data_sel,
    input  logic        flag_only,
    input  wr_width_t   alu_we,
    input  wr_width_t   ram_we,
    output logic [31:0] src_out,
    output logic [31:0] aux_out,
    output logic [31:0] dst_out,
    output logic [31:0] xsp,
    output logic        bc_unity,
    input  logic [7:0]  dmp_addr,
    output logic [7:0]  dmp_din
);

    logic [7:0]  accs [0:63];
    logic [7:0]  ptrs [0:15];

    logic [31:0] step_val;
    logic [31:0] wr_data;
    wr_width_t   we;
    logic [1:0]  cur_bank;
    logic [15:0] cur_bc;
    logic [31:0] cur_xde;
    logic [31:0] xix;
    logic [31:0] src_ptr_word;

    // long-aligned bases of the source code
    logic [1:0]  s_pb;
    logic [3:0]  s_ab;
    // destination byte addresses
    logic [3:0]  d_p;
    logic [5:0]  d_a;

    function automatic logic zero_bank(input reg_code_t c);
        return {c.acc.pad, c.acc.bank} == `REG_ZERO_BANK;
    endfunction

    // byte 0 at the code, byte 1 at the odd byte, upper half long aligned
    function automatic logic [31:0] read_word(input reg_code_t c);
        logic [5:0] a;
        logic [3:0] p;
        a = {c.acc.bank, c.acc.idx};
        p = c.ptr.idx;
        if (c.ptr.is_ptr) begin
            return {ptrs[{p[3:2], 2'd3}], ptrs[{p[3:2], 2'd2}],
                    ptrs[{p[3:1], 1'b1}], ptrs[p]};
        end
        return {accs[{a[5:2], 2'd3}], accs[{a[5:2], 2'd2}],
                accs[{a[5:1], 1'b1}], accs[a]};
    endfunction

    assign step_val = step_bytes(reg_step);
    assign wr_data  = data_sel ? ram_dout : alu_dout;
    assign we       = flag_only ? wr_width_t'(3'd0) : (data_sel ? ram_we : alu_we);
    assign cur_bank = port.rfp;

    assign s_pb = port.src_code.ptr.idx[3:2];
    assign s_ab = {port.src_code.acc.bank, port.src_code.acc.idx[3:2]};
    assign d_p  = port.dst_code.ptr.idx;
    assign d_a  = {port.dst_code.acc.bank, port.dst_code.acc.idx};

    // fixed registers of the current bank
    assign cur_bc  = {accs[{cur_bank, 4'd5}], accs[{cur_bank, 4'd4}]};
    assign cur_xde = {accs[{cur_bank, 4'hb}], accs[{cur_bank, 4'ha}],
                      accs[{cur_bank, 4'h9}], accs[{cur_bank, 4'h8}]};
    assign xix     = {ptrs[3], ptrs[2], ptrs[1], ptrs[0]};
    assign xsp     = {ptrs[15], ptrs[14], ptrs[13], ptrs[12]};

    assign src_ptr_word = {ptrs[{s_pb, 2'd3}], ptrs[{s_pb, 2'd2}],
                           ptrs[{s_pb, 2'd1}], ptrs[{s_pb, 2'd0}]};

    always_comb begin
        src_out = read_word(port.src_code);
        if (zero_bank(port.src_code)) begin
            src_out = 32'd0;
        end
        aux_out = read_word(port.aux_code);
        if (zero_bank(port.aux_code)) begin
            aux_out = 32'd0;
        end
        // predecremented view for the memory addresser
        dst_out = read_word(port.dst_code);
        if (reg_dec) begin
            dst_out = dst_out - step_val;
        end
    end

    // later statements win on the same edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 64; i++) begin
                accs[i] <= 8'd0;
            end
            for (int i = 0; i < 16; i++) begin
                ptrs[i] <= 8'd0;
            end
            bc_unity <= 1'b0;
        end else if (cen) begin
            bc_unity <= (cur_bc == 16'd1);

            if (reg_inc) begin
                {ptrs[{s_pb, 2'd3}], ptrs[{s_pb, 2'd2}],
                 ptrs[{s_pb, 2'd1}], ptrs[{s_pb, 2'd0}]} <= src_ptr_word + step_val;
            end
            if (reg_dec) begin
                if (port.src_code.ptr.is_ptr) begin
                    {ptrs[{s_pb, 2'd3}], ptrs[{s_pb, 2'd2}],
                     ptrs[{s_pb, 2'd1}], ptrs[{s_pb, 2'd0}]} <= src_ptr_word - step_val;
                end else begin
                    // compare-and-decrement on a general register
                    {accs[{s_ab, 2'd3}], accs[{s_ab, 2'd2}],
                     accs[{s_ab, 2'd1}], accs[{s_ab, 2'd0}]} <= src_out - step_val;
                end
            end

            if (dec_bc) begin
                {accs[{cur_bank, 4'd5}], accs[{cur_bank, 4'd4}]} <= cur_bc - 16'd1;
            end

            // block move decrements
            if (dec_xde) begin
                {accs[{cur_bank, 4'hb}], accs[{cur_bank, 4'ha}],
                 accs[{cur_bank, 4'h9}], accs[{cur_bank, 4'h8}]} <= cur_xde - step_val;
            end
            if (dec_xix) begin
                {ptrs[3], ptrs[2], ptrs[1], ptrs[0]} <= xix - step_val;
            end

            // stack, increment wins
            if (dec_xsp != 3'd0) begin
                {ptrs[15], ptrs[14], ptrs[13], ptrs[12]} <= xsp - {29'd0, dec_xsp};
            end
            if (inc_xsp != 3'd0) begin
                {ptrs[15], ptrs[14], ptrs[13], ptrs[12]} <= xsp + {29'd0, inc_xsp};
            end

            if (we.byte_w) begin
                if (port.dst_code.ptr.is_ptr) begin
                    ptrs[d_p] <= wr_data[7:0];
                end else begin
                    accs[d_a] <= wr_data[7:0];
                end
            end
            if (we.word_w) begin
                if (port.dst_code.ptr.is_ptr) begin
                    {ptrs[{d_p[3:1], 1'b1}], ptrs[d_p]} <= wr_data[15:0];
                end else begin
                    {accs[{d_a[5:1], 1'b1}], accs[d_a]} <= wr_data[15:0];
                end
            end
            if (we.long_w) begin
                if (port.dst_code.ptr.is_ptr) begin
                    {ptrs[{d_p[3:2], 2'd3}], ptrs[{d_p[3:2], 2'd2}],
                     ptrs[{d_p[3:2], 2'd1}], ptrs[{d_p[3:2], 2'd0}]} <= wr_data;
                end else begin
                    {accs[{d_a[5:2], 2'd3}], accs[{d_a[5:2], 2'd2}],
                     accs[{d_a[5:2], 2'd1}], accs[{d_a[5:2], 2'd0}]} <= wr_data;
                end
            end
        end
    end

    // debug dump runs on every clock
    always_ff @(posedge clk) begin
        if (dmp_addr < `DUMP_PTR_BASE) begin
            dmp_din <= accs[dmp_addr[5:0]];
        end else if (dmp_addr < `DUMP_SR_BASE) begin
            dmp_din <= ptrs[dmp_addr[3:0]];
        end else if (dmp_addr == `DUMP_SR_BASE) begin
            dmp_din <= sr[15:8];
        end else if (dmp_addr == `DUMP_SR_BASE + 8'd1) begin
            dmp_din <= sr[7:0];
        end else begin
            dmp_din <= 8'd0;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/cpu_regs_top.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// General-register subsystem top level.
// Plain ports toward the decoder, ALU and memory.
// Joins the code mapper and the storage array
// through one register port interface.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module cpu_regs_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  logic [15:0] sr,
    // bank pointer control
    output logic [1:0]  rfp,
    input  logic        inc_rfp,
    input  logic        dec_rfp,
    input  logic        rfp_we,
    input  logic [1:0]  imm,
    input  logic        dec_bc,
    output logic        bc_unity,
    // stack
    output logic [31:0] xsp,
    input  logic [2:0]  inc_xsp,
    input  logic [2:0]  dec_xsp,
    // indexed addressing
    input  logic        idx_en,
    input  logic [7:0]  idx_rdreg_sel,
    input  logic [7:0]  idx_rdreg_aux,
    input  logic [1:0]  reg_step,
    input  logic        reg_inc,
    input  logic        reg_dec,
    input  logic        dec_xde,
    input  logic        dec_xix,
    // write data
    input  logic [31:0] alu_dout,
    input  logic [31:0] ram_dout,
    input  logic        data_sel,
    input  logic [2:0]  alu_we,
    input  logic [2:0]  ram_we,
    input  logic        flag_only,
    // operands
    input  logic [7:0]  src,
    input  logic [7:0]  dst,
    output logic [31:0] src_out,
    output logic [31:0] aux_out,
    output logic [31:0] dst_out,
    // debug dump
    input  logic [7:0]  dmp_addr,
    output logic [7:0]  dmp_din
);

    reg_port_if regs_bus ();

    assign rfp = regs_bus.rfp;

    reg_code_map u_map (
        .clk           (clk),
        .rst           (rst),
        .cen           (cen),
        .inc_rfp       (inc_rfp),
        .dec_rfp       (dec_rfp),
        .rfp_we        (rfp_we),
        .imm           (imm),
        .idx_en        (idx_en),
        .src           (src),
        .dst           (dst),
        .idx_rdreg_sel (idx_rdreg_sel),
        .idx_rdreg_aux (idx_rdreg_aux),
        .port          (regs_bus.map)
    );

    reg_array u_array (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .port      (regs_bus.array),
        .sr        (sr),
        .reg_step  (reg_step),
        .reg_inc   (reg_inc),
        .reg_dec   (reg_dec),
        .dec_xde   (dec_xde),
        .dec_xix   (dec_xix),
        .dec_bc    (dec_bc),
        .inc_xsp   (inc_xsp),
        .dec_xsp   (dec_xsp),
        .alu_dout  (alu_dout),
        .ram_dout  (ram_dout),
        .data_sel  (data_sel),
        .flag_only (flag_only),
        .alu_we    (alu_we),
        .ram_we    (ram_we),
        .src_out   (src_out),
        .aux_out   (aux_out),
        .dst_out   (dst_out),
        .xsp       (xsp),
        .bc_unity  (bc_unity),
        .dmp_addr  (dmp_addr),
        .dmp_din   (dmp_din)
    );

endmodule

`default_nettype wire

// ==== sim/regs_asserts.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Concurrent checks on the code mapper and the
// register storage, attached with bind. Each bind
// ties off the ports its target does not have.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

`include "cpu_regs_macros.svh"

module regs_asserts (
    input logic        clk,
    input logic        rst,
    input logic        cen,
    input logic [1:0]  rfp,
    input logic        bc_unity,
    input logic [31:0] xsp,
    input logic        src_zero,
    input logic [31:0] src_out,
    input logic [7:0]  dmp_addr,
    input logic [7:0]  dmp_din
);

    // an edge without cen leaves the state alone
    hold_without_cen: assert property (@(posedge clk) disable iff (rst)
        !cen |=> $stable(rfp) && $stable(bc_unity) && $stable(xsp))
        else $error("register state changed on an edge without cen");

    rfp_in_reset: assert property (@(posedge clk) rst |-> rfp == 2'd0)
        else $error("rfp is not zero during reset");

    zero_source: assert property (@(posedge clk) disable iff (rst)
        src_zero |-> src_out == 32'd0)
        else $error("zero-bank source code read a nonzero value");

    // dump data follows the address by one clock
    dump_unmapped: assert property (@(posedge clk) disable iff (rst)
        (dmp_addr > `DUMP_SR_BASE + 8'd1) |=> dmp_din == 8'd0)
        else $error("dump port returned data for an unmapped address");

endmodule

bind reg_code_map regs_asserts u_map_asserts (
    .clk      (clk),
    .rst      (rst),
    .cen      (cen),
    .rfp      (rfp_q),
    .bc_unity (1'b0),
    .xsp      (32'd0),
    .src_zero (1'b0),
    .src_out  (32'd0),
    .dmp_addr (8'd0),
    .dmp_din  (8'd0)
);

bind reg_array regs_asserts u_array_asserts (
    .clk      (clk),
    .rst      (rst),
    .cen      (cen),
    .rfp      (port.rfp),
    .bc_unity (bc_unity),
    .xsp      (xsp),
    .src_zero (port.src_code[7:4] == `REG_ZERO_BANK),
    .src_out  (src_out),
    .dmp_addr (dmp_addr),
    .dmp_din  (dmp_din)
);

`default_nettype wire

// ==== sim/regs_tb.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench for the general-register
// subsystem. Drives the decoder, ALU and memory
// roles, keeps a byte-level model of the storage
// and checks reads, the dump port and the flags.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

`include "cpu_regs_macros.svh"

module regs_tb import cpu_regs_pkg::*; ();

    localparam int CLK_NS = 10;
    // reset, then reset, writes, banking, stepping and counter tests
    localparam int BUDGET = 12 + 90 + 45 + 25 + 15 + 15;

    logic        clk;
    logic        rst;
    logic        cen;
    logic [15:0] sr;
    logic [1:0]  rfp;
    logic        inc_rfp;
    logic        dec_rfp;
    logic        rfp_we;
    logic [1:0]  imm;
    logic        dec_bc;
    logic        bc_unity;
    logic [31:0] xsp;
    logic [2:0]  inc_xsp;
    logic [2:0]  dec_xsp;
    logic        idx_en;
    reg_code_t   idx_rdreg_sel;
    reg_code_t   idx_rdreg_aux;
    step_t       reg_step;
    logic        reg_inc;
    logic        reg_dec;
    logic        dec_xde;
    logic        dec_xix;
    logic [31:0] alu_dout;
    logic [31:0] ram_dout;
    logic        data_sel;
    wr_width_t   alu_we;
    wr_width_t   ram_we;
    logic        flag_only;
    reg_code_t   src;
    reg_code_t   dst;
    logic [31:0] src_out;
    logic [31:0] aux_out;
    logic [31:0] dst_out;
    logic [7:0]  dmp_addr;
    logic [7:0]  dmp_din;

    // model: general bytes 0..63, pointer bytes 64..79
    logic [7:0]  m_mem [0:79];
    logic [1:0]  m_rfp;
    logic [31:0] lfsr;
    string       cur_test;
    int          test_fail;
    int          n_pass;
    int          n_fail;

    cpu_regs_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #(BUDGET * 2 * CLK_NS);
        $display("timeout: tests did not finish within %0d cycles", BUDGET * 2);
        $display("sim failed");
        $finish;
    end

    // taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = 32'd0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] step_amount(input step_t s);
        case (s)
            2'd1:    return 32'd2;
            2'd2:    return 32'd4;
            default: return 32'd1;
        endcase
    endfunction

    // bank-relative code to physical code
    function automatic logic [7:0] phys(input logic [7:0] c);
        if (c[7:4] == `REG_CUR_BANK) begin
            return {2'b00, m_rfp, c[3:0]};
        end
        if (c[7:4] == `REG_PREV_BANK) begin
            return {2'b00, m_rfp - 2'd1, c[3:0]};
        end
        return c;
    endfunction

    // byte k of a register: code, odd partner, then long-aligned upper half
    function automatic int slot(input logic [7:0] pc, input int k);
        int base;
        base = pc[7] ? 64 + int'(pc[3:0]) : int'(pc[5:0]);
        if (k == 0) begin
            return base;
        end
        if (k == 1) begin
            return base | 1;
        end
        return (base & ~3) + k;
    endfunction

    function automatic logic [31:0] model_read(input logic [7:0] pc);
        logic [31:0] v;
        for (int k = 0; k < 4; k++) begin
            v[8*k +: 8] = m_mem[slot(pc, k)];
        end
        return v;
    endfunction

    function automatic void model_write(input logic [7:0] pc, input logic [31:0] d, input int n);
        for (int k = 0; k < n; k++) begin
            m_mem[slot(pc, k)] = d[8*k +: 8];
        end
    endfunction

    function automatic logic [7:0] dump_expect(input logic [7:0] addr);
        if (addr < `DUMP_SR_BASE) begin
            return m_mem[int'(addr)];
        end
        if (addr == `DUMP_SR_BASE) begin
            return sr[15:8];
        end
        if (addr == `DUMP_SR_BASE + 8'd1) begin
            return sr[7:0];
        end
        return 8'd0;
    endfunction

    task automatic tally(input logic ok);
        if (ok) begin
            n_pass++;
        end else begin
            n_fail++;
            test_fail++;
        end
    endtask

    task automatic check_word(input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", cur_test, exp, act);
        end
        tally(act === exp);
    endtask

    task automatic check_byte(input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", cur_test, exp, act);
        end
        tally(act === exp);
    endtask

    task automatic check_flag(input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %b actual %b", cur_test, exp, act);
        end
        tally(act === exp);
    endtask

    task automatic check_rfp(input logic [1:0] exp, input logic [1:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", cur_test, exp, act);
        end
        tally(act === exp);
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic check_src(input logic [7:0] code);
        src = code;
        #1;
        if (code[7:4] == `REG_ZERO_BANK) begin
            check_word(32'd0, src_out);
        end else begin
            check_word(model_read(phys(code)), src_out);
        end
    endtask

    task automatic check_dump(input logic [7:0] addr);
        dmp_addr = addr;
        tick();
        check_byte(dump_expect(addr), dmp_din);
    endtask

    // the unused data bus carries the inverse so a wrong select shows
    task automatic write_reg(input reg_code_t code, input logic [31:0] d,
                             input wr_width_t w, input logic use_ram);
        int n;
        n = w.long_w ? 4 : (w.word_w ? 2 : 1);
        dst = code;
        data_sel = use_ram;
        alu_dout = use_ram ? ~d : d;
        ram_dout = use_ram ? d : ~d;
        alu_we = use_ram ? wr_width_t'(3'd0) : w;
        ram_we = use_ram ? w : wr_width_t'(3'd0);
        tick();
        alu_we = 3'd0;
        ram_we = 3'd0;
        data_sel = 1'b0;
        if (cen && !flag_only) begin
            model_write(phys(code), d, n);
        end
    endtask

    task automatic rfp_op(input logic load, input logic dn, input logic up, input logic [1:0] v);
        rfp_we = load;
        dec_rfp = dn;
        inc_rfp = up;
        imm = v;
        tick();
        rfp_we = 1'b0;
        dec_rfp = 1'b0;
        inc_rfp = 1'b0;
        if (load) begin
            m_rfp = v;
        end else if (dn) begin
            m_rfp = m_rfp - 2'd1;
        end else if (up) begin
            m_rfp = m_rfp + 2'd1;
        end
        check_rfp(m_rfp, rfp);
    endtask

    // pointer step, dst_out shows the decremented value before the edge
    task automatic step_reg(input reg_code_t code, input step_t s, input logic down);
        logic [31:0] v;
        src = code;
        dst = code;
        reg_step = s;
        reg_inc = !down;
        reg_dec = down;
        #1;
        v = model_read(phys(code));
        if (down) begin
            check_word(v - step_amount(s), dst_out);
        end
        tick();
        reg_inc = 1'b0;
        reg_dec = 1'b0;
        model_write(phys(code), down ? v - step_amount(s) : v + step_amount(s), 4);
        check_src(code);
    endtask

    task automatic stack_op(input logic [2:0] up, input logic [2:0] dn);
        logic [31:0] v;
        inc_xsp = up;
        dec_xsp = dn;
        tick();
        inc_xsp = 3'd0;
        dec_xsp = 3'd0;
        v = model_read(8'hfc);
        if (up != 3'd0) begin
            v = v + {29'd0, up};
        end else if (dn != 3'd0) begin
            v = v - {29'd0, dn};
        end
        model_write(8'hfc, v, 4);
        check_word(v, xsp);
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        test_fail = 0;
    endtask

    task automatic end_test();
        $display("test %s finished with %0d errors", cur_test, test_fail);
    endtask

    task automatic test_reset();
        begin_test("reset");
        for (int a = 0; a < 82; a++) begin
            check_dump(a[7:0]);
        end
        check_rfp(2'd0, rfp);
        check_flag(1'b0, bc_unity);
        end_test();
    endtask

    task automatic test_writes();
        begin_test("writes");
        write_reg(8'he0, rand_bits(32), 3'b001, 1'b0);
        write_reg(8'he4, rand_bits(32), 3'b010, 1'b1);
        write_reg(8'he8, rand_bits(32), 3'b100, 1'b0);
        write_reg(8'hf4, rand_bits(32), 3'b100, 1'b1);
        write_reg(8'hf8, rand_bits(32), 3'b010, 1'b0);
        check_src(8'he0);
        check_src(8'he4);
        check_src(8'he8);
        check_src(8'hf4);
        check_src(8'hf8);
        for (int a = 0; a < 16; a++) begin
            check_dump(a[7:0]);
            check_dump(`DUMP_PTR_BASE + a[7:0]);
        end
        // suppressed by flag_only, then by cen low
        flag_only = 1'b1;
        write_reg(8'he8, rand_bits(32), 3'b100, 1'b0);
        flag_only = 1'b0;
        cen = 1'b0;
        write_reg(8'he0, rand_bits(32), 3'b100, 1'b1);
        cen = 1'b1;
        check_src(8'he8);
        check_src(8'he0);
        end_test();
    endtask

    task automatic test_banking();
        begin_test("banking");
        for (int b = 0; b < 4; b++) begin
            rfp_op(1'b1, 1'b0, 1'b0, 2'(b));
            write_reg(8'he0, rand_bits(32), 3'b100, 1'b0);
        end
        for (int b = 0; b < 4; b++) begin
            check_dump(8'(b * 16));
            check_dump(8'(b * 16 + 3));
        end
        rfp_op(1'b0, 1'b0, 1'b1, 2'd0);
        check_src(8'hd0);
        check_src(8'he0);
        // load beats both, then decrement beats increment
        rfp_op(1'b1, 1'b1, 1'b1, 2'd2);
        rfp_op(1'b0, 1'b1, 1'b1, 2'd0);
        end_test();
    endtask

    task automatic test_stepping();
        begin_test("stepping");
        write_reg(8'hf0, rand_bits(32), 3'b100, 1'b0);
        write_reg(8'hfc, rand_bits(32), 3'b100, 1'b1);
        for (int s = 0; s < 3; s++) begin
            step_reg(8'hf0, step_t'(s), 1'b0);
            step_reg(8'hf4, step_t'(s), 1'b1);
        end
        stack_op(3'd4, 3'd0);
        stack_op(3'd0, 3'd2);
        stack_op(3'd1, 3'd3);
        end_test();
    endtask

    task automatic test_counters();
        begin_test("counters");
        write_reg(8'he8, rand_bits(32), 3'b100, 1'b0);
        write_reg(8'hf0, rand_bits(32), 3'b100, 1'b0);
        reg_step = 2'd1;
        dec_xde = 1'b1;
        dec_xix = 1'b1;
        tick();
        dec_xde = 1'b0;
        dec_xix = 1'b0;
        model_write(phys(8'he8), model_read(phys(8'he8)) - step_amount(2'd1), 4);
        model_write(8'hf0, model_read(8'hf0) - step_amount(2'd1), 4);
        check_src(8'he8);
        check_src(8'hf0);
        // BC from 3, flag follows one edge after BC reaches 1
        write_reg(8'he4, 32'd3, 3'b010, 1'b0);
        for (int i = 0; i < 2; i++) begin
            dec_bc = 1'b1;
            tick();
            dec_bc = 1'b0;
            model_write(phys(8'he4), model_read(phys(8'he4)) - 32'd1, 2);
            check_flag(1'b0, bc_unity);
        end
        check_src(8'he4);
        tick();
        check_flag(1'b1, bc_unity);
        // plain source code differs from the index-selected one
        src = 8'he8;
        idx_rdreg_sel = 8'he4;
        idx_rdreg_aux = 8'hf4;
        idx_en = 1'b1;
        #1;
        check_word(model_read(phys(8'he4) & 8'hfb), aux_out);
        check_word(model_read(phys(8'he4)), src_out);
        check_word(model_read(8'hf4), dst_out);
        idx_en = 1'b0;
        check_src(8'h40);
        check_dump(8'h60);
        end_test();
    endtask

    initial begin
        lfsr = 32'h1ecd;
        n_pass = 0;
        n_fail = 0;
        test_fail = 0;
        cur_test = "init";
        m_rfp = 2'd0;
        for (int i = 0; i < 80; i++) begin
            m_mem[i] = 8'd0;
        end
        cen = 1'b1;
        sr = 16'(rand_bits(16));
        inc_rfp = 1'b0;
        dec_rfp = 1'b0;
        rfp_we = 1'b0;
        imm = 2'd0;
        dec_bc = 1'b0;
        inc_xsp = 3'd0;
        dec_xsp = 3'd0;
        idx_en = 1'b0;
        idx_rdreg_sel = 8'h00;
        idx_rdreg_aux = 8'h00;
        reg_step = 2'd0;
        reg_inc = 1'b0;
        reg_dec = 1'b0;
        dec_xde = 1'b0;
        dec_xix = 1'b0;
        alu_dout = 32'd0;
        ram_dout = 32'd0;
        data_sel = 1'b0;
        alu_we = 3'd0;
        ram_we = 3'd0;
        flag_only = 1'b0;
        src = 8'h00;
        dst = 8'h00;
        dmp_addr = 8'h00;
        rst = 1'b0;
        #2;
        rst = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset();
        test_writes();
        test_banking();
        test_stepping();
        test_counters();
        $display("checks passed %0d failed %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+include
verilog/cpu_regs_pkg.sv
verilog/reg_port_if.sv
verilog/reg_code_map.sv
verilog/reg_array.sv
verilog/cpu_regs_top.sv
sim/regs_asserts.sv
sim/regs_tb.sv

// ==== Makefile ====
# Verilator build of the general-register testbench

TOP = regs_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -o $(TOP)

run: compile
	@out=$$(./obj_dir/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx 'sim passed'

clean:
	rm -rf obj_dir
